//--- hw/axi_udp_pkg.sv
`default_nettype none

package axi_udp_pkg;

    localparam int word_w  = 32;
    localparam int addr_w  = 32;
    localparam int len_w   = 8;
    localparam int id_w    = 4;
    localparam int burst_w = 2;
    localparam int resp_w  = 2;
    localparam int strb_w  = 4;

    localparam logic [7:0] cmd_marker  = 8'h00;
    localparam logic [7:0] data_marker = 8'hff;

    localparam int addr_q_depth  = 16;
    localparam int wdata_q_depth = 512;
    localparam int bresp_q_depth = 16;

    // first word on top, address word below
    typedef struct packed {
        logic [7:0]         marker;   // 63:56
        logic [burst_w-1:0] burst;    // 55:54
        logic [1:0]         id;       // 53:52
        logic [2:0]         rsvd_hi;
        logic               wr;       // 48
        logic [len_w-1:0]   len;      // 47:40
        logic [7:0]         rsvd_lo;
        logic [addr_w-1:0]  addr;
    } desc_t;

    typedef struct packed {
        logic [7:0]        marker;    // 31:24
        logic [3:0]        pad_a;
        logic [id_w-1:0]   id;        // 19:16
        logic [5:0]        pad_b;
        logic [resp_w-1:0] resp;      // 9:8
        logic [7:0]        pad_c;
    } bresp_word_t;

    typedef enum logic [1:0] {
        parse_idle,
        parse_cmd_collect,
        parse_data_forward,
        parse_drain
    } parse_state_t;

    typedef enum logic [1:0] {
        issue_idle,
        issue_fetch,
        issue_present
    } issue_state_t;

endpackage

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int width = 32,
    parameter int depth = 16
) (
    input  wire              clk,
    input  wire              rstn,
    input  wire              push,
    input  wire  [width-1:0] push_data,
    input  wire              pop,
    output logic [width-1:0] pop_data,
    output logic             full,
    output logic             empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == cnt_w'(depth));
    assign empty   = (count == '0);
    assign do_push = push && !full;   // overflow word is lost
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
        if (do_pop) begin
            pop_data <= mem[rd_ptr];   // valid the cycle after pop
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        !(push && full) && !(pop && empty))
        else $error("sync_fifo: push while full or pop while empty");

endmodule

`default_nettype wire

//--- hw/udp_cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module udp_cmd_parser
    import axi_udp_pkg::*;
(
    input  wire               gmii_rx_clk,
    input  wire               rstn,
    input  wire               udp_rx_en,
    input  wire  [word_w-1:0] udp_rx_data,
    input  wire               udp_rx_done,
    output logic              wr_desc_push,
    output logic              rd_desc_push,
    output desc_t             desc,
    output logic              wdata_push,
    output logic [word_w-1:0] wdata,
    output logic              wdata_last
);

    parse_state_t      state;
    parse_state_t      state_nxt;
    logic              have_first;   // first word of a pair is held
    logic [word_w-1:0] first_word;
    logic [7:0]        top_byte;
    desc_t             desc_nxt;
    logic              desc_done;
    logic              desc_ok;

    assign top_byte  = udp_rx_data[word_w-1 -: 8];
    assign desc_nxt  = desc_t'({first_word, udp_rx_data});
    assign desc_done = udp_rx_en && (state == parse_cmd_collect) && have_first;
    assign desc_ok   = (desc_nxt.marker == cmd_marker);

    always_comb begin
        state_nxt = state;
        case (state)
            parse_idle: begin
                if (udp_rx_en && !udp_rx_done) begin   // single-word packets carry nothing
                    if (top_byte == cmd_marker) begin
                        state_nxt = parse_cmd_collect;
                    end else if (top_byte == data_marker) begin
                        state_nxt = parse_data_forward;
                    end else begin
                        state_nxt = parse_drain;
                    end
                end
            end
            parse_cmd_collect, parse_data_forward, parse_drain: begin
                if (udp_rx_en && udp_rx_done) begin
                    state_nxt = parse_idle;
                end
            end
            default: state_nxt = parse_idle;
        endcase
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state        <= parse_idle;
            have_first   <= 1'b0;
            wr_desc_push <= 1'b0;
            rd_desc_push <= 1'b0;
            wdata_push   <= 1'b0;
        end else begin
            state        <= state_nxt;
            wr_desc_push <= desc_done && desc_ok && desc_nxt.wr;
            rd_desc_push <= desc_done && desc_ok && !desc_nxt.wr;
            wdata_push   <= udp_rx_en && (state == parse_data_forward);
            if (udp_rx_en && udp_rx_done) begin
                have_first <= 1'b0;   // odd trailing word is dropped
            end else if (udp_rx_en && (state_nxt == parse_cmd_collect)) begin
                have_first <= !have_first;
            end
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (udp_rx_en && !have_first) begin
            first_word <= udp_rx_data;
        end
        if (desc_done) begin
            desc <= desc_nxt;
        end
        if (udp_rx_en && (state == parse_data_forward)) begin
            wdata      <= udp_rx_data;
            wdata_last <= udp_rx_done;
        end
    end

endmodule

`default_nettype wire

//--- hw/axi_addr_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module axi_addr_issuer
    import axi_udp_pkg::*;
(
    input  wire                gmii_rx_clk,
    input  wire                rstn,
    input  wire                desc_push,
    input  wire  desc_t        desc,
    input  wire                addr_ready,
    output logic [id_w-1:0]    addr_id,
    output logic [addr_w-1:0]  addr,
    output logic [len_w-1:0]   addr_len,
    output logic [burst_w-1:0] addr_burst,
    output logic               addr_valid
);

    issue_state_t state;
    desc_t        head;      // holds until the next pop
    logic         q_pop;
    logic         q_empty;

    sync_fifo #(
        .width ($bits(desc_t)),
        .depth (addr_q_depth)
    ) u_desc_q (
        .clk       (gmii_rx_clk),
        .rstn      (rstn),
        .push      (desc_push),
        .push_data (desc),
        .pop       (q_pop),
        .pop_data  (head),
        .full      (),
        .empty     (q_empty)
    );

    assign q_pop      = (state == issue_idle) && !q_empty;
    assign addr_valid = (state == issue_present);

    assign addr_id    = id_w'(head.id);
    assign addr       = head.addr;
    assign addr_len   = head.len;
    assign addr_burst = head.burst;

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state <= issue_idle;
        end else begin
            case (state)
                issue_idle: begin
                    if (!q_empty) begin
                        state <= issue_fetch;
                    end
                end
                issue_fetch: begin
                    state <= issue_present;   // queue output now loaded
                end
                issue_present: begin
                    if (addr_ready) begin
                        state <= issue_idle;
                    end
                end
                default: state <= issue_idle;
            endcase
        end
    end

    a_addr_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        addr_valid && !addr_ready |=>
            addr_valid && $stable({addr_id, addr, addr_len, addr_burst}))
        else $error("axi_addr_issuer: address payload changed while stalled");

endmodule

`default_nettype wire

//--- hw/axi_wdata_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wdata_issuer
    import axi_udp_pkg::*;
(
    input  wire               gmii_rx_clk,
    input  wire               rstn,
    input  wire               wdata_push,
    input  wire  [word_w-1:0] wdata,
    input  wire               wdata_last,
    input  wire               wdata_ready,
    output logic [word_w-1:0] wdata_out,
    output logic [strb_w-1:0] wstrb,
    output logic              wlast,
    output logic              wdata_valid
);

    localparam int cnt_w = $clog2(wdata_q_depth + 1);

    logic [word_w:0]  q_head;    // {last, word}
    logic             q_pop;
    logic             q_empty;
    logic             q_full;
    logic [cnt_w-1:0] pkt_cnt;   // packets fully queued, not yet sent
    logic             pkt_in;
    logic             pkt_out;
    logic             xfer;

    sync_fifo #(
        .width (word_w + 1),
        .depth (wdata_q_depth)
    ) u_wdata_q (
        .clk       (gmii_rx_clk),
        .rstn      (rstn),
        .push      (wdata_push),
        .push_data ({wdata_last, wdata}),
        .pop       (q_pop),
        .pop_data  (q_head),
        .full      (q_full),
        .empty     (q_empty)
    );

    assign xfer    = wdata_valid && wdata_ready;
    assign pkt_in  = wdata_push && wdata_last && !q_full;
    assign pkt_out = xfer && wlast;

    // only start a burst once its last word is queued, so valid never gaps
    assign q_pop = !q_empty && (!wdata_valid || xfer) && (pkt_cnt > cnt_w'(pkt_out));

    assign wdata_out = q_head[word_w-1:0];
    assign wlast     = q_head[word_w];
    assign wstrb     = {strb_w{1'b1}};

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wdata_valid <= 1'b0;
            pkt_cnt     <= '0;
        end else begin
            pkt_cnt <= pkt_cnt + cnt_w'(pkt_in) - cnt_w'(pkt_out);
            if (q_pop) begin
                wdata_valid <= 1'b1;   // prefetch keeps beats back to back
            end else if (xfer) begin
                wdata_valid <= 1'b0;
            end
        end
    end

    a_wdata_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        wdata_valid && !wdata_ready |=> wdata_valid && $stable({wdata_out, wlast}))
        else $error("axi_wdata_issuer: beat changed while stalled");

    a_burst_unbroken: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        xfer && !wlast |=> wdata_valid)
        else $error("axi_wdata_issuer: valid dropped inside a burst");

endmodule

`default_nettype wire

//--- hw/axi_bresp_collector.sv
`timescale 1ns/1ps
`default_nettype none

module axi_bresp_collector
    import axi_udp_pkg::*;
(
    input  wire                gmii_rx_clk,
    input  wire                rstn,
    input  wire   [id_w-1:0]   bid,
    input  wire   [resp_w-1:0] bresp,
    input  wire                bvalid,
    input  wire                bresp_pop,
    output logic               bready,
    output bresp_word_t        bresp_data,
    output logic               bresp_empty
);

    localparam int lvl_w = $clog2(bresp_q_depth + 1);

    bresp_word_t      status;
    logic             status_push;
    logic             accept;
    logic             q_pop;
    logic [lvl_w-1:0] level;       // queued plus the one in flight
    logic [lvl_w-1:0] level_nxt;

    sync_fifo #(
        .width ($bits(bresp_word_t)),
        .depth (bresp_q_depth)
    ) u_bresp_q (
        .clk       (gmii_rx_clk),
        .rstn      (rstn),
        .push      (status_push),
        .push_data (status),
        .pop       (q_pop),
        .pop_data  (bresp_data),
        .full      (),
        .empty     (bresp_empty)
    );

    assign accept    = bvalid && bready;
    assign q_pop     = bresp_pop && !bresp_empty;
    assign level_nxt = level + lvl_w'(accept) - lvl_w'(q_pop);

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            bready      <= 1'b0;
            status_push <= 1'b0;
            level       <= '0;
        end else begin
            level       <= level_nxt;
            bready      <= (level_nxt < lvl_w'(bresp_q_depth));   // room for one more
            status_push <= accept;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (accept) begin
            status <= '{marker: data_marker, id: bid, resp: bresp, default: '0};
        end
    end

endmodule

`default_nettype wire

//--- hw/axi_udp_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module axi_udp_cmd
    import axi_udp_pkg::*;
(
    input  wire                gmii_rx_clk,
    input  wire                rstn,
    // udp receive
    input  wire                udp_rx_en,
    input  wire  [word_w-1:0]  udp_rx_data,
    input  wire                udp_rx_done,
    // write address
    output logic [id_w-1:0]    m_axi_awid,
    output logic [addr_w-1:0]  m_axi_awaddr,
    output logic [len_w-1:0]   m_axi_awlen,
    output logic [burst_w-1:0] m_axi_awburst,
    output logic               m_axi_awvalid,
    input  wire                m_axi_awready,
    // write data
    output logic [word_w-1:0]  m_axi_wdata,
    output logic [strb_w-1:0]  m_axi_wstrb,
    output logic               m_axi_wlast,
    output logic               m_axi_wvalid,
    input  wire                m_axi_wready,
    // write response
    input  wire  [id_w-1:0]    m_axi_bid,
    input  wire  [resp_w-1:0]  m_axi_bresp,
    input  wire                m_axi_bvalid,
    output logic               m_axi_bready,
    // read address
    output logic [id_w-1:0]    m_axi_arid,
    output logic [addr_w-1:0]  m_axi_araddr,
    output logic [len_w-1:0]   m_axi_arlen,
    output logic [burst_w-1:0] m_axi_arburst,
    output logic               m_axi_arvalid,
    input  wire                m_axi_arready,
    // status readout
    input  wire                bresp_pop,
    output logic [word_w-1:0]  bresp_data,
    output logic               bresp_empty
);

    desc_t             desc;
    logic              wr_desc_push;
    logic              rd_desc_push;
    logic              wdata_push;
    logic [word_w-1:0] wdata;
    logic              wdata_last;

    udp_cmd_parser u_parser (
        .gmii_rx_clk  (gmii_rx_clk),
        .rstn         (rstn),
        .udp_rx_en    (udp_rx_en),
        .udp_rx_data  (udp_rx_data),
        .udp_rx_done  (udp_rx_done),
        .wr_desc_push (wr_desc_push),
        .rd_desc_push (rd_desc_push),
        .desc         (desc),
        .wdata_push   (wdata_push),
        .wdata        (wdata),
        .wdata_last   (wdata_last)
    );

    axi_addr_issuer u_aw_issuer (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .desc_push   (wr_desc_push),
        .desc        (desc),
        .addr_ready  (m_axi_awready),
        .addr_id     (m_axi_awid),
        .addr        (m_axi_awaddr),
        .addr_len    (m_axi_awlen),
        .addr_burst  (m_axi_awburst),
        .addr_valid  (m_axi_awvalid)
    );

    axi_addr_issuer u_ar_issuer (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .desc_push   (rd_desc_push),
        .desc        (desc),
        .addr_ready  (m_axi_arready),
        .addr_id     (m_axi_arid),
        .addr        (m_axi_araddr),
        .addr_len    (m_axi_arlen),
        .addr_burst  (m_axi_arburst),
        .addr_valid  (m_axi_arvalid)
    );

    axi_wdata_issuer u_w_issuer (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .wdata_push  (wdata_push),
        .wdata       (wdata),
        .wdata_last  (wdata_last),
        .wdata_ready (m_axi_wready),
        .wdata_out   (m_axi_wdata),
        .wstrb       (m_axi_wstrb),
        .wlast       (m_axi_wlast),
        .wdata_valid (m_axi_wvalid)
    );

    axi_bresp_collector u_b_collector (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .bid         (m_axi_bid),
        .bresp       (m_axi_bresp),
        .bvalid      (m_axi_bvalid),
        .bresp_pop   (bresp_pop),
        .bready      (m_axi_bready),
        .bresp_data  (bresp_data),
        .bresp_empty (bresp_empty)
    );

endmodule

`default_nettype wire

//--- sim/tb_vectors.svh
`ifndef tb_vectors_svh
`define tb_vectors_svh

// rx rows are en, done, payload word
typedef struct packed {
    logic        en;
    logic        done;
    logic [31:0] data;
} rx_row_t;

typedef struct packed {
    logic [3:0]  id;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [1:0]  burst;
} addr_xfer_t;

typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
    logic        last;
} w_xfer_t;

// response id and code from the slave, then the status word it should become
typedef struct packed {
    logic [3:0]  id;
    logic [1:0]  code;
    logic [31:0] status;
} b_row_t;

localparam int n_rx = 22;
localparam int n_aw = 2;
localparam int n_ar = 2;
localparam int n_w  = 5;
localparam int n_b  = 2;

localparam rx_row_t rx_tab [n_rx] = '{
    '{1'b1, 1'b0, 32'h0061_0300},   // write, burst 1, id 2, len 3
    '{1'b1, 1'b0, 32'h1000_0040},
    '{1'b1, 1'b0, 32'h0090_0700},   // read, burst 2, id 1, len 7
    '{1'b1, 1'b1, 32'h2000_0100},
    '{1'b0, 1'b0, 32'h0000_0000},
    '{1'b1, 1'b0, 32'h0071_0000},   // write, burst 1, id 3, len 0
    '{1'b1, 1'b0, 32'h3000_0000},
    '{1'b1, 1'b0, 32'h5a61_0300},   // bad marker, dropped
    '{1'b1, 1'b0, 32'hdead_beef},
    '{1'b1, 1'b0, 32'h0000_0f00},   // read, burst 0, id 0, len 15
    '{1'b1, 1'b1, 32'h4000_0080},
    '{1'b1, 1'b0, 32'hff00_0000},   // data header
    '{1'b1, 1'b0, 32'ha5a5_0001},
    '{1'b1, 1'b0, 32'h1234_5678},
    '{1'b1, 1'b1, 32'h0bad_f00d},
    '{1'b0, 1'b0, 32'h0000_0000},
    '{1'b0, 1'b0, 32'h0000_0000},
    '{1'b1, 1'b0, 32'h7700_0000},   // unknown marker, drained
    '{1'b1, 1'b1, 32'h0000_1234},
    '{1'b1, 1'b0, 32'hff00_0001},   // data header
    '{1'b1, 1'b0, 32'hcafe_0001},
    '{1'b1, 1'b1, 32'hcafe_0002}
};

localparam addr_xfer_t aw_exp [n_aw] = '{
    '{4'h2, 32'h1000_0040, 8'h03, 2'b01},
    '{4'h3, 32'h3000_0000, 8'h00, 2'b01}
};

localparam addr_xfer_t ar_exp [n_ar] = '{
    '{4'h1, 32'h2000_0100, 8'h07, 2'b10},
    '{4'h0, 32'h4000_0080, 8'h0f, 2'b00}
};

localparam w_xfer_t w_exp [n_w] = '{
    '{32'ha5a5_0001, 4'hf, 1'b0},
    '{32'h1234_5678, 4'hf, 1'b0},
    '{32'h0bad_f00d, 4'hf, 1'b1},
    '{32'hcafe_0001, 4'hf, 1'b0},
    '{32'hcafe_0002, 4'hf, 1'b1}
};

localparam b_row_t b_tab [n_b] = '{
    '{4'h2, 2'b00, 32'hff02_0000},
    '{4'ha, 2'b11, 32'hff0a_0300}
};

`endif

//--- sim/tb_axi_udp_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_udp_cmd;

    `include "tb_vectors.svh"

    localparam logic [31:0] rand_seed    = 32'h6c5b_0962;
    localparam int          reset_cycles = 16;
    localparam int          stall_budget = 200;   // random ready stalls and pipeline latency
    localparam int          cycle_limit  = reset_cycles + 4 * n_rx + stall_budget;

    logic        gmii_rx_clk = 1'b0;
    logic        rstn;
    logic        udp_rx_en;
    logic [31:0] udp_rx_data;
    logic        udp_rx_done;
    logic [3:0]  m_axi_awid;
    logic [31:0] m_axi_awaddr;
    logic [7:0]  m_axi_awlen;
    logic [1:0]  m_axi_awburst;
    logic        m_axi_awvalid;
    logic        m_axi_awready;
    logic [31:0] m_axi_wdata;
    logic [3:0]  m_axi_wstrb;
    logic        m_axi_wlast;
    logic        m_axi_wvalid;
    logic        m_axi_wready;
    logic [3:0]  m_axi_bid;
    logic [1:0]  m_axi_bresp;
    logic        m_axi_bvalid;
    logic        m_axi_bready;
    logic [3:0]  m_axi_arid;
    logic [31:0] m_axi_araddr;
    logic [7:0]  m_axi_arlen;
    logic [1:0]  m_axi_arburst;
    logic        m_axi_arvalid;
    logic        m_axi_arready;
    logic        bresp_pop;
    logic [31:0] bresp_data;
    logic        bresp_empty;

    addr_xfer_t aw_now;
    addr_xfer_t ar_now;
    w_xfer_t    w_now;
    addr_xfer_t aw_prev;
    addr_xfer_t ar_prev;
    w_xfer_t    w_prev;
    logic       aw_stalled = 1'b0;
    logic       ar_stalled = 1'b0;
    logic       w_stalled  = 1'b0;
    addr_xfer_t aw_got [$];
    addr_xfer_t ar_got [$];
    w_xfer_t    w_got [$];
    int         w_bursts = 0;   // bursts whose last beat was taken
    int         b_acked  = 0;
    int         cycle_cnt;

    axi_udp_cmd UUT (.*);

    always #5 gmii_rx_clk = ~gmii_rx_clk;

    assign aw_now = {m_axi_awid, m_axi_awaddr, m_axi_awlen, m_axi_awburst};
    assign ar_now = {m_axi_arid, m_axi_araddr, m_axi_arlen, m_axi_arburst};
    assign w_now  = {m_axi_wdata, m_axi_wstrb, m_axi_wlast};

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // slave side, ready stalls and write responses
    initial begin
        void'($urandom(rand_seed));
        m_axi_awready = 1'b0;
        m_axi_arready = 1'b0;
        m_axi_wready  = 1'b0;
        m_axi_bvalid  = 1'b0;
        m_axi_bid     = '0;
        m_axi_bresp   = '0;
        forever begin
            @(posedge gmii_rx_clk);
            if (rstn) begin
                m_axi_awready <= ($urandom % 4) != 0;
                m_axi_arready <= ($urandom % 4) != 0;
                m_axi_wready  <= ($urandom % 4) != 0;
                if (m_axi_bvalid && m_axi_bready) begin
                    m_axi_bvalid <= 1'b0;
                    b_acked      <= b_acked + 1;
                end else if (!m_axi_bvalid && b_acked < w_bursts && b_acked < n_b) begin
                    m_axi_bid    <= b_tab[b_acked].id;
                    m_axi_bresp  <= b_tab[b_acked].code;
                    m_axi_bvalid <= 1'b1;
                end
            end
        end
    end

    // transfer monitors with hold checks under stall
    always @(posedge gmii_rx_clk) begin
        if (rstn) begin
            if (aw_stalled) begin
                compare_value("aw valid held", 1, m_axi_awvalid);
                compare_value("aw payload held", aw_prev, aw_now);
            end
            if (ar_stalled) begin
                compare_value("ar valid held", 1, m_axi_arvalid);
                compare_value("ar payload held", ar_prev, ar_now);
            end
            if (w_stalled) begin
                compare_value("w valid held", 1, m_axi_wvalid);
                compare_value("w beat held", w_prev, w_now);
            end
            aw_stalled <= m_axi_awvalid && !m_axi_awready;
            ar_stalled <= m_axi_arvalid && !m_axi_arready;
            w_stalled  <= m_axi_wvalid && !m_axi_wready;
            aw_prev    <= aw_now;
            ar_prev    <= ar_now;
            w_prev     <= w_now;
            if (m_axi_awvalid && m_axi_awready) begin
                aw_got.push_back(aw_now);
            end
            if (m_axi_arvalid && m_axi_arready) begin
                ar_got.push_back(ar_now);
            end
            if (m_axi_wvalid && m_axi_wready) begin
                w_got.push_back(w_now);
                if (m_axi_wlast) begin
                    w_bursts <= w_bursts + 1;
                end
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge gmii_rx_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, expected transfers never completed", cycle_cnt);
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        int idx;
        rstn        = 1'b0;
        udp_rx_en   = 1'b0;
        udp_rx_data = '0;
        udp_rx_done = 1'b0;
        bresp_pop   = 1'b0;
        repeat (reset_cycles) @(posedge gmii_rx_clk);
        compare_value("reset awvalid", 0, m_axi_awvalid);
        compare_value("reset arvalid", 0, m_axi_arvalid);
        compare_value("reset wvalid", 0, m_axi_wvalid);
        compare_value("reset bready", 0, m_axi_bready);
        compare_value("reset bresp_empty", 1, bresp_empty);
        rstn <= 1'b1;

        for (int i = 0; i < n_rx; i++) begin
            @(posedge gmii_rx_clk);
            udp_rx_en   <= rx_tab[i].en;
            udp_rx_data <= rx_tab[i].data;
            udp_rx_done <= rx_tab[i].done;
        end
        @(posedge gmii_rx_clk);
        udp_rx_en   <= 1'b0;
        udp_rx_done <= 1'b0;

        while (aw_got.size() < n_aw || ar_got.size() < n_ar || w_got.size() < n_w
               || b_acked < n_b) begin
            @(posedge gmii_rx_clk);
        end
        repeat (20) @(posedge gmii_rx_clk);   // quiet window, nothing extra may show up

        compare_value("aw count", n_aw, aw_got.size());
        compare_value("ar count", n_ar, ar_got.size());
        compare_value("w count", n_w, w_got.size());
        for (int i = 0; i < n_aw; i++) begin
            compare_value($sformatf("aw transfer %0d", i), aw_exp[i], aw_got[i]);
        end
        for (int i = 0; i < n_ar; i++) begin
            compare_value($sformatf("ar transfer %0d", i), ar_exp[i], ar_got[i]);
        end
        for (int i = 0; i < n_w; i++) begin
            compare_value($sformatf("w beat %0d", i), w_exp[i], w_got[i]);
        end

        // pop then read, data lands one cycle after the pop
        idx = 0;
        while (!bresp_empty) begin
            if (idx >= n_b) begin
                $display("status queue holds more words than responses returned");
                $display("Test failed");
                $fatal(1, "extra status word");
            end
            bresp_pop <= 1'b1;
            @(posedge gmii_rx_clk);
            bresp_pop <= 1'b0;
            @(posedge gmii_rx_clk);
            compare_value($sformatf("status word %0d", idx), b_tab[idx].status, bresp_data);
            idx++;
        end
        compare_value("status count", n_b, idx);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+sim
hw/axi_udp_pkg.sv
hw/sync_fifo.sv
hw/udp_cmd_parser.sv
hw/axi_addr_issuer.sv
hw/axi_wdata_issuer.sv
hw/axi_bresp_collector.sv
hw/axi_udp_cmd.sv
sim/tb_axi_udp_cmd.sv

//--- Bender.yml
package:
  name: axi_udp_cmd

sources:
  - hw/axi_udp_pkg.sv
  - hw/sync_fifo.sv
  - hw/udp_cmd_parser.sv
  - hw/axi_addr_issuer.sv
  - hw/axi_wdata_issuer.sv
  - hw/axi_bresp_collector.sv
  - hw/axi_udp_cmd.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_axi_udp_cmd.sv
